/* frontend_pkg.sv */
// Shared constants and the fetched-word type of the next-fetch-address stage
// Imported by every front-end module and by the testbench
`default_nettype none

package frontend_pkg;

	localparam int addr_width = 64; // Width of every pc and fetch address
	localparam logic [addr_width-1:0] reset_vector = 64'h0000_0000_8000_0000;

	localparam int ras_depth_log2 = 4; // Default return stack depth is 16 entries
	localparam int resolve_depth_log2 = 4; // Default resolve queue depth is 16 entries

	// Register numbers that mark a jump as a call or a return
	localparam logic [4:0] link_reg_x1 = 5'd1;
	localparam logic [4:0] link_reg_x5 = 5'd5;

	// 32-bit RVI view of a fetched word
	typedef struct packed {
		logic [6:0] funct7; // Also carries imm[12|10:5] of B and imm[20|10:5] of J
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd; // Holds imm[4:1|11] in the B format
		logic [6:0] opcode;
	} rvi_instr_t;

	// 16-bit RVC view, the instruction sits in the low half
	typedef struct packed {
		logic [15:0] upper; // Next parcel, not part of this instruction
		logic [15:0] rvc;
	} rvc_instr_t;

	// Low two bits equal to 11 select the full view
	typedef union packed {
		rvi_instr_t full;
		rvc_instr_t comp;
	} rv_instr_u;

endpackage

`default_nettype wire

/* instr_predecode.sv */
// Combinational predecoder that classifies one fetched word for branch prediction
// Handles the 32-bit jumps and branches and the RVC jump and branch forms
`timescale 1ns/100ps
`default_nettype none

module instr_predecode (
	input  frontend_pkg::rv_instr_u instr,
	output logic is_branch,
	output logic is_jal,
	output logic is_jalr,
	output logic is_call,
	output logic is_return,
	output logic is_rvc,
	output logic [frontend_pkg::addr_width-1:0] imm
);
	import frontend_pkg::*;

	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_jalr = 7'b1100111;

	rvi_instr_t w; // Full view
	logic [15:0] c; // Compressed view
	logic [addr_width-1:0] imm_b;
	logic [addr_width-1:0] imm_j;
	logic [addr_width-1:0] imm_cb;
	logic [addr_width-1:0] imm_cj;
	logic rd_link;
	logic rs1_link;
	logic c_jr_form;

	assign w = instr.full;
	assign c = instr.comp.rvc;
	assign is_rvc = (w.opcode[1:0] != 2'b11);

	assign imm_b = {{52{w.funct7[6]}}, w.rd[0], w.funct7[5:0], w.rd[4:1], 1'b0};
	assign imm_j = {{44{w.funct7[6]}}, w.rs1, w.funct3, w.rs2[0], w.funct7[5:0], w.rs2[4:1], 1'b0};
	assign imm_cb = {{56{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
	assign imm_cj = {{53{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};

	assign rd_link = (w.rd == link_reg_x1) || (w.rd == link_reg_x5);
	assign rs1_link = (w.rs1 == link_reg_x1) || (w.rs1 == link_reg_x5);
	// c.jr and c.jalr share quadrant 2, funct3 100, a nonzero rs1 and a zero rs2
	assign c_jr_form = (c[1:0] == 2'b10) && (c[15:13] == 3'b100) &&
		(c[11:7] != 5'd0) && (c[6:2] == 5'd0);

	always_comb begin
		is_branch = 1'b0;
		is_jal = 1'b0;
		is_jalr = 1'b0;
		is_call = 1'b0;
		is_return = 1'b0;
		imm = '0; // Also the jalr value, its target comes from the stack or execute
		if (is_rvc) begin
			if (c[1:0] == 2'b01 && c[15:14] == 2'b11) begin // c.beqz and c.bnez
				is_branch = 1'b1;
				imm = imm_cb;
			end else if (c[1:0] == 2'b01 && c[14:13] == 2'b01) begin // c.j and c.jal
				is_jal = 1'b1;
				is_call = ~c[15]; // c.jal writes x1
				imm = imm_cj;
			end else if (c_jr_form) begin
				is_jalr = 1'b1;
				is_call = c[12]; // c.jalr writes x1
				is_return = ~c[12] && ((c[11:7] == link_reg_x1) || (c[11:7] == link_reg_x5));
			end
		end else begin
			case (w.opcode)
				opc_branch: begin
					is_branch = 1'b1;
					imm = imm_b;
				end
				opc_jal: begin
					is_jal = 1'b1;
					is_call = rd_link;
					imm = imm_j;
				end
				opc_jalr: begin
					is_jalr = 1'b1;
					is_call = rd_link;
					is_return = rs1_link && !rd_link;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* return_stack.sv */
// Ring-buffer return-address stack, a push while full drops the oldest entry
// Push and pop are single-cycle strobes and the top entry reads combinationally
`timescale 1ns/100ps
`default_nettype none

module return_stack #(
	parameter int depth_log2 = frontend_pkg::ras_depth_log2
) (
	input  logic CLK,
	input  logic reset,
	input  logic push,
	input  logic pop,
	input  logic flush,
	input  logic [frontend_pkg::addr_width-1:0] push_addr,
	output logic [frontend_pkg::addr_width-1:0] pop_addr,
	output logic empty
);
	import frontend_pkg::*;

	localparam int depth = 1 << depth_log2;

	logic [addr_width-1:0] mem [depth];
	logic [depth_log2-1:0] top; // Index of the most recent entry
	logic [depth_log2-1:0] top_inc;
	logic [depth_log2:0] count; // Saturates at depth

	assign top_inc = top + 1'b1;
	assign empty = (count == '0);
	assign pop_addr = mem[top];

	always_ff @(posedge CLK) begin
		if (reset) begin
			top <= '0;
			count <= '0;
		end else if (flush) begin
			count <= '0; // Old entries become unreachable
		end else if (push && !pop) begin
			top <= top_inc; // Wraps onto the oldest entry when full
			if (count != (depth_log2 + 1)'(depth))
				count <= count + 1'b1;
		end else if (pop && !push) begin
			top <= top - 1'b1;
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (push && !flush) begin
			if (pop)
				mem[top] <= push_addr; // Pop and push together replace the top
			else
				mem[top_inc] <= push_addr;
		end
	end

	// The predictor only pops when it has seen the stack non-empty
	pop_nonempty: assert property (@(posedge CLK) disable iff (reset) pop |-> !empty)
		else $error("return stack popped while empty");

endmodule

`default_nettype wire

/* resolve_fifo.sv */
// Queue of predicted directions and alternative addresses for unresolved branches
// Bit 64 is the predicted direction, the low bits the address used on a wrong guess
`timescale 1ns/100ps
`default_nettype none

module resolve_fifo #(
	parameter int depth_log2 = frontend_pkg::resolve_depth_log2
) (
	input  logic CLK,
	input  logic reset,
	input  logic push,
	input  logic pop,
	input  logic flush,
	input  logic [frontend_pkg::addr_width:0] push_data,
	output logic [frontend_pkg::addr_width:0] pop_data,
	output logic full,
	output logic empty
);
	import frontend_pkg::*;

	localparam int depth = 1 << depth_log2;

	logic [addr_width:0] mem [depth];
	logic [depth_log2:0] wp; // Extra msb tells full from empty
	logic [depth_log2:0] rp;

	assign empty = (wp == rp);
	assign full = (wp[depth_log2] != rp[depth_log2]) &&
		(wp[depth_log2-1:0] == rp[depth_log2-1:0]);
	assign pop_data = mem[rp[depth_log2-1:0]];

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			wp <= '0;
			rp <= '0;
		end else begin
			if (push)
				wp <= wp + 1'b1;
			if (pop)
				rp <= rp + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (push)
			mem[wp[depth_log2-1:0]] <= push_data; // Discarded by the pointer reset on flush
	end

	// A branch is held in fetch while the queue is full
	push_not_full: assert property (@(posedge CLK) disable iff (reset) push |-> !full)
		else $error("resolve queue pushed while full");

	pop_not_empty: assert property (@(posedge CLK) disable iff (reset) pop |-> !empty)
		else $error("resolve queue popped while empty");

endmodule

`default_nettype wire

/* branch_predict.sv */
// Static branch predictor that registers the next fetch address and its valid flag
// Redirect priority is reset, exception, mispredict and then the predicted path
`timescale 1ns/100ps
`default_nettype none

module branch_predict #(
	parameter int ras_depth_log2 = frontend_pkg::ras_depth_log2,
	parameter int resolve_depth_log2 = frontend_pkg::resolve_depth_log2
) (
	input  logic CLK,
	input  logic reset,
	input  logic is_branch,
	input  logic is_jal,
	input  logic is_jalr,
	input  logic is_call,
	input  logic is_return,
	input  logic is_rvc,
	input  logic [frontend_pkg::addr_width-1:0] imm,
	input  logic [frontend_pkg::addr_width-1:0] fetch_pc,
	input  logic fetch_pc_valid,
	input  logic fetch_ready,
	input  logic jalr_valid,
	input  logic [frontend_pkg::addr_width-1:0] jalr_pc,
	input  logic bru_res_valid,
	input  logic bru_taken,
	input  logic exception,
	input  logic [frontend_pkg::addr_width-1:0] exception_pc,
	output logic [frontend_pkg::addr_width-1:0] fetch_addr,
	output logic fetch_addr_valid,
	output logic mispredict
);
	import frontend_pkg::*;

	logic [addr_width-1:0] next_pc; // Fall-through address
	logic [addr_width-1:0] take_pc; // Predicted target when taken
	logic [addr_width-1:0] fetch_addr_dnxt;
	logic fetch_addr_valid_dnxt;
	logic taken;
	logic use_ras;
	logic branch_stall;
	logic jalr_stall;
	logic advance;
	logic accept;
	logic flush;

	logic ras_push;
	logic ras_pop;
	logic ras_empty;
	logic [addr_width-1:0] ras_pop_addr;

	logic res_push;
	logic res_full;
	logic res_empty;
	logic [addr_width:0] res_push_data;
	logic [addr_width:0] res_pop_data;

	// Backward conditional branches and all jumps are predicted taken
	assign taken = (is_branch && imm[addr_width-1]) || is_jal || is_jalr;
	assign use_ras = is_return && !ras_empty; // A return with a known target needs no execute
	assign next_pc = fetch_pc + (is_rvc ? 64'd2 : 64'd4);
	assign take_pc = (is_jal || is_branch) ? fetch_pc + imm :
		use_ras ? ras_pop_addr : jalr_pc;

	assign branch_stall = is_branch && res_full;
	assign jalr_stall = is_jalr && !jalr_valid && !use_ras;
	assign advance = fetch_pc_valid && fetch_ready && !branch_stall && !jalr_stall;

	assign mispredict = bru_res_valid && (bru_taken ^ res_pop_data[addr_width]);
	assign flush = mispredict || exception;
	assign accept = advance && !flush; // The slot is dropped on any redirect

	always_comb begin
		if (exception)
			fetch_addr_dnxt = exception_pc;
		else if (mispredict)
			fetch_addr_dnxt = res_pop_data[addr_width-1:0];
		else if (advance)
			fetch_addr_dnxt = taken ? take_pc : next_pc;
		else
			fetch_addr_dnxt = fetch_pc; // Hold while stalled or back-pressured
	end
	assign fetch_addr_valid_dnxt = advance || flush;

	always_ff @(posedge CLK) begin
		if (reset) begin
			fetch_addr <= reset_vector;
			fetch_addr_valid <= 1'b1; // Reset itself is a redirect
		end else begin
			fetch_addr <= fetch_addr_dnxt;
			fetch_addr_valid <= fetch_addr_valid_dnxt;
		end
	end

	assign ras_push = is_call && accept;
	assign ras_pop = use_ras && accept;

	// The queue keeps whichever address the prediction did not follow
	assign res_push = is_branch && accept;
	assign res_push_data = {taken, taken ? next_pc : take_pc};

	return_stack #(
		.depth_log2(ras_depth_log2)
	) i_ras (
		.CLK(CLK),
		.reset(reset),
		.push(ras_push),
		.pop(ras_pop),
		.flush(flush),
		.push_addr(next_pc),
		.pop_addr(ras_pop_addr),
		.empty(ras_empty)
	);

	resolve_fifo #(
		.depth_log2(resolve_depth_log2)
	) i_resolve (
		.CLK(CLK),
		.reset(reset),
		.push(res_push),
		.pop(bru_res_valid),
		.flush(flush),
		.push_data(res_push_data),
		.pop_data(res_pop_data),
		.full(res_full),
		.empty(res_empty)
	);

	// Execute only reports outcomes for branches this stage has queued
	bru_has_entry: assert property (@(posedge CLK) disable iff (reset)
		bru_res_valid |-> !res_empty)
		else $error("branch result with no queued prediction");

endmodule

`default_nettype wire

/* fetch_frontend.sv */
// Top level of the next-fetch-address stage
// The predecoder feeds the static predictor, which owns the return stack and resolve queue
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend #(
	parameter int ras_depth_log2 = frontend_pkg::ras_depth_log2,
	parameter int resolve_depth_log2 = frontend_pkg::resolve_depth_log2
) (
	input  logic CLK,
	input  logic reset,
	input  frontend_pkg::rv_instr_u instr,
	input  logic [frontend_pkg::addr_width-1:0] fetch_pc,
	input  logic fetch_pc_valid,
	input  logic fetch_ready,
	input  logic jalr_valid,
	input  logic [frontend_pkg::addr_width-1:0] jalr_pc,
	input  logic bru_res_valid,
	input  logic bru_taken,
	input  logic exception,
	input  logic [frontend_pkg::addr_width-1:0] exception_pc,
	output logic [frontend_pkg::addr_width-1:0] fetch_addr,
	output logic fetch_addr_valid,
	output logic mispredict
);
	import frontend_pkg::*;

	logic is_branch;
	logic is_jal;
	logic is_jalr;
	logic is_call;
	logic is_return;
	logic is_rvc;
	logic [addr_width-1:0] imm; // Sign-extended offset of the fetched word

	instr_predecode i_predecode (
		.instr(instr),
		.is_branch(is_branch),
		.is_jal(is_jal),
		.is_jalr(is_jalr),
		.is_call(is_call),
		.is_return(is_return),
		.is_rvc(is_rvc),
		.imm(imm)
	);

	branch_predict #(
		.ras_depth_log2(ras_depth_log2),
		.resolve_depth_log2(resolve_depth_log2)
	) i_predict (
		.CLK(CLK),
		.reset(reset),
		.is_branch(is_branch),
		.is_jal(is_jal),
		.is_jalr(is_jalr),
		.is_call(is_call),
		.is_return(is_return),
		.is_rvc(is_rvc),
		.imm(imm),
		.fetch_pc(fetch_pc),
		.fetch_pc_valid(fetch_pc_valid),
		.fetch_ready(fetch_ready),
		.jalr_valid(jalr_valid),
		.jalr_pc(jalr_pc),
		.bru_res_valid(bru_res_valid),
		.bru_taken(bru_taken),
		.exception(exception),
		.exception_pc(exception_pc),
		.fetch_addr(fetch_addr),
		.fetch_addr_valid(fetch_addr_valid),
		.mispredict(mispredict)
	);

endmodule

`default_nettype wire

/* tb_fetch_frontend.sv */
// Table-driven testbench for the next-fetch-address stage
// Each row is driven for one cycle, mispredict is checked in that cycle and the address one edge later
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_frontend;
	import frontend_pkg::*;

	localparam int reset_timeout = 20; // Cycles allowed for the reset redirect to show

	// Control bits are {fetch_pc_valid, fetch_ready, jalr_valid, bru_res_valid, bru_taken, exception}
	// and side_pc drives exception_pc when exception is set, jalr_pc otherwise
	typedef struct packed {
		rv_instr_u instr;
		logic [addr_width-1:0] pc;
		logic [5:0] ctl;
		logic [addr_width-1:0] side_pc;
		logic [addr_width-1:0] exp_addr;
		logic exp_valid;
		logic exp_misp;
	} row_t;

	logic CLK;
	logic reset;
	rv_instr_u instr;
	logic [addr_width-1:0] fetch_pc;
	logic fetch_pc_valid;
	logic fetch_ready;
	logic jalr_valid;
	logic [addr_width-1:0] jalr_pc;
	logic bru_res_valid;
	logic bru_taken;
	logic exception;
	logic [addr_width-1:0] exception_pc;
	logic [addr_width-1:0] fetch_addr;
	logic fetch_addr_valid;
	logic mispredict;

	row_t rows[$];
	string names[$];

	fetch_frontend i_dut (
		.CLK(CLK),
		.reset(reset),
		.instr(instr),
		.fetch_pc(fetch_pc),
		.fetch_pc_valid(fetch_pc_valid),
		.fetch_ready(fetch_ready),
		.jalr_valid(jalr_valid),
		.jalr_pc(jalr_pc),
		.bru_res_valid(bru_res_valid),
		.bru_taken(bru_taken),
		.exception(exception),
		.exception_pc(exception_pc),
		.fetch_addr(fetch_addr),
		.fetch_addr_valid(fetch_addr_valid),
		.mispredict(mispredict)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK; // 10 ns period
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_addr(input string name, input logic [addr_width-1:0] expected,
		input logic [addr_width-1:0] actual);
		if (actual !== expected)
			fail_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			fail_run($sformatf("mismatch %s expected %b actual %b", name, expected, actual));
	endtask

	task automatic add_row(input string name, input logic [31:0] word,
		input logic [addr_width-1:0] pc, input logic [5:0] ctl,
		input logic [addr_width-1:0] side_pc, input logic [addr_width-1:0] exp_addr,
		input logic exp_valid, input logic exp_misp);
		row_t r;
		r.instr = rv_instr_u'(word);
		r.pc = pc;
		r.ctl = ctl;
		r.side_pc = side_pc;
		r.exp_addr = exp_addr;
		r.exp_valid = exp_valid;
		r.exp_misp = exp_misp;
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic drive_row(input row_t r);
		instr <= r.instr;
		fetch_pc <= r.pc;
		{fetch_pc_valid, fetch_ready, jalr_valid, bru_res_valid, bru_taken, exception} <= r.ctl;
		// The other of the two pcs gets the complement so the targets cannot be confused
		jalr_pc <= r.ctl[0] ? ~r.side_pc : r.side_pc;
		exception_pc <= r.ctl[0] ? r.side_pc : ~r.side_pc;
	endtask

	// Words: nop 00000013, c.nop 0001, beq -8 FE000CE3, beq +8 00000463, jal x0 +16 0100006F,
	// jal x1 +256 100000EF, jalr x0 0(x1) 00008067, c.jr x1 8082, c.j +8 A021, c.beqz -4 DC75
	task automatic build_table();
		add_row("seq_nop32", 32'h0000_0013, 64'h8000_0000, 6'b11_0_00_0, '0, 64'h8000_0004, 1, 0);
		add_row("seq_cnop", 32'h0000_0001, 64'h8000_0004, 6'b11_0_00_0, '0, 64'h8000_0006, 1, 0);
		add_row("hold_ready", 32'h0000_0013, 64'h8000_0006, 6'b10_0_00_0, '0, 64'h8000_0006, 0, 0);
		add_row("hold_valid", 32'h0000_0013, 64'h8000_0006, 6'b01_0_00_0, '0, 64'h8000_0006, 0, 0);
		add_row("seq_resume", 32'h0000_0013, 64'h8000_0006, 6'b11_0_00_0, '0, 64'h8000_000A, 1, 0);
		add_row("beq_back", 32'hFE00_0CE3, 64'h8000_0100, 6'b11_0_00_0, '0, 64'h8000_00F8, 1, 0);
		add_row("beq_fwd", 32'h0000_0463, 64'h8000_00F8, 6'b11_0_00_0, '0, 64'h8000_00FC, 1, 0);
		add_row("jal_fwd", 32'h0100_006F, 64'h8000_0200, 6'b11_0_00_0, '0, 64'h8000_0210, 1, 0);
		add_row("cj_fwd", 32'h0000_A021, 64'h8000_0210, 6'b11_0_00_0, '0, 64'h8000_0218, 1, 0);
		add_row("cbeqz_back", 32'h0000_DC75, 64'h8000_0218, 6'b11_0_00_0, '0, 64'h8000_0214, 1, 0);
		// Outcomes arrive in queue order: beq_back taken, beq_fwd not taken
		add_row("bru_agree_taken", 32'h0000_0013, 64'h8000_0214, 6'b11_0_11_0, '0,
			64'h8000_0218, 1, 0);
		add_row("bru_agree_fall", 32'h0000_0001, 64'h8000_0218, 6'b11_0_10_0, '0,
			64'h8000_021A, 1, 0);
		add_row("call", 32'h1000_00EF, 64'h8000_0300, 6'b11_0_00_0, '0, 64'h8000_0400, 1, 0);
		add_row("cret", 32'h0000_8082, 64'h8000_0400, 6'b11_0_00_0, '0, 64'h8000_0304, 1, 0);
		add_row("call2", 32'h1000_00EF, 64'h8000_0500, 6'b11_0_00_0, '0, 64'h8000_0600, 1, 0);
		add_row("ret32", 32'h0000_8067, 64'h8000_0600, 6'b11_0_00_0, '0, 64'h8000_0504, 1, 0);
		add_row("ret_empty_wait", 32'h0000_8082, 64'h8000_0700, 6'b11_0_00_0, '0,
			64'h8000_0700, 0, 0);
		add_row("ret_empty_jalr", 32'h0000_8082, 64'h8000_0700, 6'b11_1_00_0, 64'h8000_0880,
			64'h8000_0880, 1, 0);
		add_row("call3", 32'h1000_00EF, 64'h8000_0900, 6'b11_0_00_0, '0, 64'h8000_0A00, 1, 0);
		// cbeqz_back was predicted taken, so its fall-through is the redirect
		add_row("bru_wrong_taken", 32'h0000_0013, 64'h8000_0A00, 6'b11_0_10_0, '0,
			64'h8000_021A, 1, 1);
		add_row("ret_after_flush", 32'h0000_8082, 64'h8000_021A, 6'b11_0_00_0, '0,
			64'h8000_021A, 0, 0);
		add_row("ret_flush_jalr", 32'h0000_8082, 64'h8000_021A, 6'b11_1_00_0, 64'h8000_0B00,
			64'h8000_0B00, 1, 0);
		add_row("beq_fwd2", 32'h0000_0463, 64'h8000_0D00, 6'b11_0_00_0, '0, 64'h8000_0D04, 1, 0);
		add_row("bru_wrong_fall", 32'h0000_0013, 64'h8000_0D04, 6'b11_0_11_0, '0,
			64'h8000_0D08, 1, 1);
		add_row("beq_back2", 32'hFE00_0CE3, 64'h8000_0C00, 6'b11_0_00_0, '0, 64'h8000_0BF8, 1, 0);
		add_row("exc_over_misp", 32'h0000_0013, 64'h8000_0BF8, 6'b11_0_10_1, 64'h0000_1000,
			64'h0000_1000, 1, 1);
		add_row("exc_alone", 32'h0000_0013, 64'h0000_1000, 6'b11_0_00_1, 64'h0000_2000,
			64'h0000_2000, 1, 0);
		add_row("exc_stalled", 32'h0000_0013, 64'h0000_2000, 6'b00_0_00_1, 64'h0000_3000,
			64'h0000_3000, 1, 0);
		add_row("cnop_after_exc", 32'h0000_0001, 64'h0000_3000, 6'b11_0_00_0, '0,
			64'h0000_3002, 1, 0);
	endtask

	initial begin
		int waited;
		int last;
		row_t idle;
		idle = '0; // Nothing valid, no strobes
		reset = 1'b1;
		instr = '0;
		fetch_pc = '0;
		fetch_pc_valid = 1'b0;
		fetch_ready = 1'b0;
		jalr_valid = 1'b0;
		jalr_pc = '0;
		bru_res_valid = 1'b0;
		bru_taken = 1'b0;
		exception = 1'b0;
		exception_pc = '0;
		build_table();
		repeat (3) @(posedge CLK);
		reset <= 1'b0;

		waited = 0;
		@(negedge CLK);
		while (fetch_addr_valid !== 1'b1) begin
			if (waited == reset_timeout)
				fail_run("fetch_addr_valid did not rise after reset");
			else begin
				@(negedge CLK);
				waited++;
			end
		end
		check_addr("reset_vector", reset_vector, fetch_addr);
		check_flag("reset_mispredict", 1'b0, mispredict);

		for (int i = 0; i < rows.size(); i++) begin
			@(posedge CLK);
			drive_row(rows[i]);
			@(negedge CLK);
			if (i > 0) begin // The previous row has now passed its capture edge
				check_addr(names[i-1], rows[i-1].exp_addr, fetch_addr);
				check_flag({names[i-1], " valid"}, rows[i-1].exp_valid, fetch_addr_valid);
			end else begin
				check_flag("reset_redirect_end", 1'b0, fetch_addr_valid); // Idle inputs follow reset
			end
			check_flag({names[i], " mispredict"}, rows[i].exp_misp, mispredict);
		end
		last = rows.size() - 1;
		@(posedge CLK);
		drive_row(idle);
		@(negedge CLK);
		check_addr(names[last], rows[last].exp_addr, fetch_addr);
		check_flag({names[last], " valid"}, rows[last].exp_valid, fetch_addr_valid);

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
frontend_pkg.sv
instr_predecode.sv
return_stack.sv
resolve_fifo.sv
branch_predict.sv
fetch_frontend.sv
tb_fetch_frontend.sv

/* run.sh */
#!/bin/sh
# Builds the fetch front-end testbench with Verilator and runs it
# The exit status is nonzero when the build fails or the testbench stops with $fatal
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert \
	--top-module tb_fetch_frontend \
	-f vlog.f \
	-o sim_fetch_frontend \
	&& ./obj_dir/sim_fetch_frontend \
	|| exit 1
